// File: hw/rename_pkg.sv
package rename_pkg;

    localparam int NUM_ARCH = 32;                // RV32I integer registers

    typedef logic [4:0] arch_reg_t;
    typedef logic [5:0] phys_reg_t;              // Wide enough for up to 64 physical registers

    // RV32I major opcodes, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        opc_illegal = 7'b0000000,
        opc_load    = 7'b0000011,
        opc_op_imm  = 7'b0010011,
        opc_auipc   = 7'b0010111,
        opc_store   = 7'b0100011,
        opc_op      = 7'b0110011,
        opc_lui     = 7'b0110111,
        opc_branch  = 7'b1100011,
        opc_jalr    = 7'b1100111,
        opc_jal     = 7'b1101111
    } rv_opcode_e;

    typedef struct packed {
        rv_opcode_e opcode;
        arch_reg_t  rs1;
        arch_reg_t  rs2;
        arch_reg_t  rd;
        logic       uses_rs1;
        logic       uses_rs2;
        logic       writes_rd;                   // Already low for rd == x0
    } decoded_uop_t;

    typedef struct packed {
        rv_opcode_e opcode;
        arch_reg_t  rd;
        phys_reg_t  prs1;                        // Physical 0 when the source is unused
        phys_reg_t  prs2;
        phys_reg_t  prd;
        phys_reg_t  old_prd;                     // Mapping of rd before this uop
        logic       writes_rd;
    } renamed_uop_t;

    // In-order retirement of one renamed uop
    typedef struct packed {
        arch_reg_t rd;
        phys_reg_t prd;
        phys_reg_t old_prd;
        logic      writes_rd;
    } commit_t;

endpackage

// File: hw/inst_decode.sv
`timescale 1ns/1ps

module inst_decode
    import rename_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         flush,
    input  logic         inst_valid,
    input  logic [31:0]  inst,
    output logic         inst_ready,
    output logic         dec_valid,
    output decoded_uop_t dec_uop,
    input  logic         dec_ready
);

    rv_opcode_e   opc;
    decoded_uop_t dec_next;
    logic         use1;
    logic         use2;
    logic         wr;

    assign opc = rv_opcode_e'(inst[6:0]);

    // Register use by major opcode
    always_comb begin
        use1 = 1'b0;
        use2 = 1'b0;
        wr   = 1'b0;
        dec_next.opcode = opc;
        case (opc)
            opc_op: begin
                use1 = 1'b1;
                use2 = 1'b1;
                wr   = 1'b1;
            end
            opc_branch, opc_store: begin
                use1 = 1'b1;
                use2 = 1'b1;
            end
            opc_op_imm, opc_load, opc_jalr: begin
                use1 = 1'b1;
                wr   = 1'b1;
            end
            opc_lui, opc_auipc, opc_jal: wr = 1'b1;
            default: dec_next.opcode = opc_illegal;   // Unknown encodings use nothing
        endcase
        dec_next.rs1       = inst[19:15];
        dec_next.rs2       = inst[24:20];
        dec_next.rd        = inst[11:7];
        dec_next.uses_rs1  = use1;
        dec_next.uses_rs2  = use2;
        dec_next.writes_rd = wr && (inst[11:7] != '0);  // x0 is never renamed
    end

    // One-entry stage, refills when empty or drained downstream
    assign inst_ready = !flush && (!dec_valid || dec_ready);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            dec_valid <= 1'b0;
        end else if (!dec_valid || dec_ready) begin
            dec_valid <= inst_valid;
        end
        if (inst_valid && inst_ready) begin
            dec_uop <= dec_next;
        end
    end

endmodule

// File: hw/free_list.sv
`timescale 1ns/1ps

module free_list
    import rename_pkg::*;
#(
    parameter int NUM_PHYS = 64
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,
    input  logic      alloc_req,
    output phys_reg_t alloc_preg,
    output logic      empty,
    input  logic      free_valid,
    input  phys_reg_t free_preg,
    input  logic      commit_alloc
);

    // Registers beyond the architectural set; a power of two so the pointers wrap freely
    localparam int DEPTH  = NUM_PHYS - NUM_ARCH;
    localparam int IDX_W  = $clog2(DEPTH);
    localparam int PHYS_W = $clog2(NUM_PHYS);

    logic [PHYS_W-1:0] entries [DEPTH];

    // Extra top bit separates a full list from an empty one
    logic [IDX_W:0] wr_ptr;                      // Free side, commits push here
    logic [IDX_W:0] alloc_ptr;                   // Speculative read side
    logic [IDX_W:0] commit_ptr;                  // Read side as seen by retirement
    logic [IDX_W:0] commit_ptr_next;
    logic [IDX_W:0] occupancy;

    assign occupancy  = wr_ptr - alloc_ptr;
    assign empty      = (occupancy == '0);
    assign alloc_preg = phys_reg_t'(entries[alloc_ptr[IDX_W-1:0]]);

    // A commit in the flush cycle is part of the restored state
    assign commit_ptr_next = commit_ptr + {{IDX_W{1'b0}}, commit_alloc};

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= (IDX_W+1)'(DEPTH);    // Starts full
            alloc_ptr  <= '0;
            commit_ptr <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                entries[i] <= PHYS_W'(NUM_ARCH + i);
            end
        end else begin
            commit_ptr <= commit_ptr_next;

            if (flush) begin
                alloc_ptr <= commit_ptr_next;   // Drop every speculative allocation
            end else if (alloc_req) begin
                alloc_ptr <= alloc_ptr + 1'b1;
            end

            // Returned register is visible to allocation from the next cycle
            if (free_valid) begin
                entries[wr_ptr[IDX_W-1:0]] <= free_preg[PHYS_W-1:0];
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

endmodule

// File: hw/rename_table.sv
`timescale 1ns/1ps

module rename_table
    import rename_pkg::*;
#(
    parameter int NUM_PHYS = 64
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic                       dec_valid,
    input  decoded_uop_t               dec_uop,
    output logic                       dec_ready,
    output logic                       alloc_req,
    input  phys_reg_t                  alloc_preg,
    input  logic                       empty,
    input  phys_reg_t [NUM_ARCH-1:0]   committed_map,
    output logic                       out_valid,
    output renamed_uop_t               out_uop,
    input  logic                       out_ready
);

    localparam int PHYS_W = $clog2(NUM_PHYS);

    logic [PHYS_W-1:0] spec_map [NUM_ARCH];     // Speculative arch to phys map
    renamed_uop_t      ren_next;
    logic              stage_open;
    logic              accept;

    assign stage_open = !out_valid || out_ready;

    // A destination needs a free register, sources never stall
    assign dec_ready = !flush && stage_open && (!dec_uop.writes_rd || !empty);
    assign accept    = dec_valid && dec_ready;
    assign alloc_req = accept && dec_uop.writes_rd;

    // Lookups see the map before this uop's own update
    always_comb begin
        ren_next.opcode    = dec_uop.opcode;
        ren_next.rd        = dec_uop.rd;
        ren_next.prs1      = dec_uop.uses_rs1 ? phys_reg_t'(spec_map[dec_uop.rs1]) : '0;
        ren_next.prs2      = dec_uop.uses_rs2 ? phys_reg_t'(spec_map[dec_uop.rs2]) : '0;
        ren_next.prd       = dec_uop.writes_rd ? alloc_preg : '0;
        ren_next.old_prd   = dec_uop.writes_rd ? phys_reg_t'(spec_map[dec_uop.rd]) : '0;
        ren_next.writes_rd = dec_uop.writes_rd;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            for (int i = 0; i < NUM_ARCH; i++) begin
                spec_map[i] <= PHYS_W'(i);       // Identity map
            end
        end else if (flush) begin
            out_valid <= 1'b0;
            for (int i = 0; i < NUM_ARCH; i++) begin
                spec_map[i] <= committed_map[i][PHYS_W-1:0];
            end
        end else begin
            if (alloc_req) begin
                spec_map[dec_uop.rd] <= alloc_preg[PHYS_W-1:0];
            end
            if (stage_open) begin
                out_valid <= accept;
            end
        end
    end

    // Payload only, qualified by out_valid
    always_ff @(posedge clk) begin
        if (accept) begin
            out_uop <= ren_next;
        end
    end

endmodule

// File: hw/retire_map.sv
`timescale 1ns/1ps

module retire_map
    import rename_pkg::*;
#(
    parameter int NUM_PHYS = 64
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     commit_valid,
    input  commit_t                  commit,
    output phys_reg_t [NUM_ARCH-1:0] committed_map,
    output logic                     free_valid,
    output phys_reg_t                free_preg,
    output logic                     commit_alloc
);

    localparam int PHYS_W = $clog2(NUM_PHYS);

    logic [PHYS_W-1:0] arch_map [NUM_ARCH];     // Non-speculative arch to phys map
    logic              retire_wr;

    assign retire_wr = commit_valid && commit.writes_rd;

    // The previous mapping is dead once its successor retires
    assign free_valid   = retire_wr;
    assign free_preg    = commit.old_prd;
    assign commit_alloc = retire_wr;

    // Forward the commit of this cycle so a flush restore includes it
    always_comb begin
        for (int i = 0; i < NUM_ARCH; i++) begin
            committed_map[i] = phys_reg_t'(arch_map[i]);
        end
        if (retire_wr) begin
            committed_map[commit.rd] = commit.prd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_ARCH; i++) begin
                arch_map[i] <= PHYS_W'(i);
            end
        end else if (retire_wr) begin
            arch_map[commit.rd] <= commit.prd[PHYS_W-1:0];
        end
    end

endmodule

// File: hw/rename_top.sv
`timescale 1ns/1ps

module rename_top
    import rename_pkg::*;
#(
    parameter int NUM_PHYS = 64
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         flush,
    input  logic         inst_valid,
    input  logic [31:0]  inst,
    output logic         inst_ready,
    output logic         out_valid,
    output renamed_uop_t out_uop,
    input  logic         out_ready,
    input  logic         commit_valid,
    input  commit_t      commit
);

    // Decode to rename handshake
    logic         dec_valid;
    logic         dec_ready;
    decoded_uop_t dec_uop;

    // Allocation side of the free list
    logic         alloc_req;
    phys_reg_t    alloc_preg;
    logic         empty;

    // Retirement side
    phys_reg_t [NUM_ARCH-1:0] committed_map;
    logic                     free_valid;
    phys_reg_t                free_preg;
    logic                     commit_alloc;

    inst_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_ready (inst_ready),
        .dec_valid  (dec_valid),
        .dec_uop    (dec_uop),
        .dec_ready  (dec_ready)
    );

    rename_table #(.NUM_PHYS(NUM_PHYS)) u_rename (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .dec_valid     (dec_valid),
        .dec_uop       (dec_uop),
        .dec_ready     (dec_ready),
        .alloc_req     (alloc_req),
        .alloc_preg    (alloc_preg),
        .empty         (empty),
        .committed_map (committed_map),
        .out_valid     (out_valid),
        .out_uop       (out_uop),
        .out_ready     (out_ready)
    );

    free_list #(.NUM_PHYS(NUM_PHYS)) u_free_list (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .alloc_req    (alloc_req),
        .alloc_preg   (alloc_preg),
        .empty        (empty),
        .free_valid   (free_valid),
        .free_preg    (free_preg),
        .commit_alloc (commit_alloc)
    );

    retire_map #(.NUM_PHYS(NUM_PHYS)) u_retire (
        .clk           (clk),
        .rst           (rst),
        .commit_valid  (commit_valid),
        .commit        (commit),
        .committed_map (committed_map),
        .free_valid    (free_valid),
        .free_preg     (free_preg),
        .commit_alloc  (commit_alloc)
    );

endmodule

// File: testbench/rename_assert.sv
`timescale 1ns/1ps

module rename_assert
    import rename_pkg::*;
#(
    parameter int CAPACITY = 32
) (
    input logic         clk,
    input logic         rst,
    input logic         flush,
    input logic         alloc_req,
    input logic         empty,
    input logic [5:0]   occupancy,
    input logic         out_valid,
    input logic         out_ready,
    input renamed_uop_t out_uop
);

    // No allocation out of an empty list
    a_alloc_not_empty: assert property (@(posedge clk) disable iff (rst) alloc_req |-> !empty)
        else $error("Allocation requested while the free list is empty");

    a_occupancy: assert property (@(posedge clk) disable iff (rst) int'(occupancy) <= CAPACITY)
        else $error("Free list occupancy above its capacity");

    // Output payload held under back-pressure
    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> $stable(out_uop))
        else $error("Renamed uop changed while stalled");

    a_flush_drop: assert property (@(posedge clk) disable iff (rst) flush |=> !out_valid)
        else $error("Output still valid after a flush");

endmodule

// File: testbench/rename_tb.sv
`timescale 1ns/1ps

module rename_tb
    import rename_pkg::*;
();

    localparam int MAX_REC = 64;

    logic         clk;
    logic         rst;
    logic         flush;
    logic         inst_valid;
    logic [31:0]  inst;
    logic         inst_ready;
    logic         out_valid;
    renamed_uop_t out_uop;
    logic         out_ready;
    logic         commit_valid;
    commit_t      commit;

    string        rec_kind [MAX_REC];
    string        rec_name [MAX_REC];
    int           rec_rep [MAX_REC];
    logic [31:0]  rec_word [MAX_REC];
    renamed_uop_t rec_exp [MAX_REC];
    int           num_rec;
    logic         loaded;

    renamed_uop_t exp_q[$];                     // Expected output order
    string        name_q[$];
    int           seed = 74;
    int           rnd;

    rename_top uut (
        .clk(clk), .rst(rst), .flush(flush),
        .inst_valid(inst_valid), .inst(inst), .inst_ready(inst_ready),
        .out_valid(out_valid), .out_uop(out_uop), .out_ready(out_ready),
        .commit_valid(commit_valid), .commit(commit)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_uop(input string name, input renamed_uop_t exp, input renamed_uop_t act);
        if (act !== exp) begin
            report_failure($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("FAIL %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        string       line;
        string       kind;
        string       name;
        int          rep;
        logic [31:0] word;
        logic [31:0] f_opc, f_rd, f_p1, f_p2, f_pd, f_po, f_wr;
        fd = $fopen("testbench/rename_golden.txt", "r");
        if (fd == 0) begin
            report_failure("Cannot open the golden data file");
        end
        num_rec = 0;
        while (!$feof(fd) && num_rec < MAX_REC) begin
            n = $fgets(line, fd);
            if (n == 0 || line.getc(0) == 8'h23) begin
                continue;                        // Blank or comment line
            end
            n = $sscanf(line, "%s %s %d %h %h %h %h %h %h %h %h", kind, name, rep, word,
                        f_opc, f_rd, f_p1, f_p2, f_pd, f_po, f_wr);
            if (n == 11) begin
                rec_kind[num_rec] = kind;
                rec_name[num_rec] = name;
                rec_rep[num_rec]  = rep;
                rec_word[num_rec] = word;
                rec_exp[num_rec]  = '{opcode: rv_opcode_e'(f_opc[6:0]), rd: f_rd[4:0],
                                      prs1: f_p1[5:0], prs2: f_p2[5:0], prd: f_pd[5:0],
                                      old_prd: f_po[5:0], writes_rd: f_wr[0]};
                num_rec++;
            end
        end
        $fclose(fd);
    endtask

    // Repeats step rd, prd and old_prd by one each
    function automatic renamed_uop_t step_uop(input renamed_uop_t base, input int i);
        renamed_uop_t u;
        u = base;
        u.rd      = arch_reg_t'(int'(base.rd) + i);
        u.prd     = phys_reg_t'(int'(base.prd) + i);
        u.old_prd = phys_reg_t'(int'(base.old_prd) + i);
        return u;
    endfunction

    // Valid stays high on return, the next call replaces the word without a bubble
    task automatic send_inst(input string name, input logic [31:0] word, input renamed_uop_t exp);
        @(negedge clk);
        inst       = word;
        inst_valid = 1'b1;
        exp_q.push_back(exp);
        name_q.push_back(name);
        #40;                                    // Settled well before the edge
        while (!inst_ready) begin
            @(negedge clk);
            #40;
        end
    endtask

    task automatic send_commit(input renamed_uop_t c);
        @(negedge clk);
        commit_valid = 1'b1;
        commit = '{rd: c.rd, prd: c.prd, old_prd: c.old_prd, writes_rd: c.writes_rd};
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // Random back-pressure and in-order output compare
    always @(negedge clk) begin
        rnd = $random(seed);
        out_ready = rnd[0];
        #1;
        if (!rst && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                report_failure("Renamed uop on the output with none expected");
            end else begin
                check_uop(name_q.pop_front(), exp_q.pop_front(), out_uop);
            end
        end
    end

    initial begin
        wait (loaded === 1'b1);
        #(num_rec * 200 * 100);
        report_failure("Timeout: the run did not finish in time");
    end

    initial begin
        rst = 1'b1;
        flush = 1'b0;
        inst_valid = 1'b0;
        inst = '0;
        commit_valid = 1'b0;
        commit = '0;
        out_ready = 1'b0;
        loaded = 1'b0;
        load_golden();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk) rst = 1'b0;
        for (int r = 0; r < num_rec; r++) begin
            if (rec_kind[r] == "inst") begin
                for (int i = 0; i < rec_rep[r]; i++) begin
                    send_inst(rec_name[r], rec_word[r] + (32'(i) << 7), step_uop(rec_exp[r], i));
                end
                // Consecutive inst records stay back to back
                if (r + 1 == num_rec || rec_kind[r + 1] != "inst") begin
                    @(negedge clk) inst_valid = 1'b0;
                end
            end else if (rec_kind[r] == "commit") begin
                for (int i = 0; i < rec_rep[r]; i++) begin
                    send_commit(step_uop(rec_exp[r], i));
                end
                @(negedge clk) commit_valid = 1'b0;
            end else if (rec_kind[r] == "idle") begin
                repeat (rec_rep[r]) @(negedge clk);
                #40 check_flag(rec_name[r], rec_exp[r].writes_rd, inst_ready);
            end else if (rec_kind[r] == "flush") begin
                wait_drained();                  // Nothing in flight gets dropped
                @(negedge clk) flush = 1'b1;
                @(negedge clk) flush = 1'b0;
            end else begin
                report_failure($sformatf("Unknown record kind %s", rec_kind[r]));
            end
        end
        wait_drained();
        repeat (5) @(negedge clk);
        $display("Everything OK");
        $finish;
    end

endmodule

bind rename_top rename_assert u_checks (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush),
    .alloc_req (alloc_req),
    .empty     (empty),
    .occupancy (u_free_list.occupancy),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_uop   (out_uop)
);

// File: testbench/rename_golden.txt
# kind name rep word opcode rd prs1 prs2 prd old_prd writes_rd (rep decimal, the rest hex)
# commit rows fill rd prd old_prd writes_rd; idle rows wait rep cycles, inst_ready expected in writes_rd
inst indep_writes 5 00100093 13 01 00 00 20 01 1
inst dep_add 1 00508333 33 06 20 24 25 06 1
inst store_no_dest 1 00112023 23 00 21 20 00 00 0
inst branch_no_dest 1 00418063 63 00 22 23 00 00 0
inst write_x0 1 00008013 13 00 20 00 00 00 0
inst fill_list 25 000003b7 37 07 00 00 26 07 1
inst last_free 1 00108093 13 01 20 00 3f 20 1
inst held_alloc 1 00110113 13 02 21 00 01 21 1
idle list_empty 4 00000000 00 00 00 00 00 00 0
commit retire_five 5 00000000 00 01 00 00 20 01 1
flush restore 0 00000000 00 00 00 00 00 00 0
inst after_flush 1 00108093 13 01 20 00 25 20 1
inst after_flush_dep 1 00208333 33 06 25 21 26 06 1

// File: files.f
hw/rename_pkg.sv
hw/inst_decode.sv
hw/free_list.sv
hw/rename_table.sv
hw/retire_map.sv
hw/rename_top.sv
testbench/rename_assert.sv
testbench/rename_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module rename_tb -f files.f -o rename_sim \
    && ./obj_dir/rename_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Everything OK" sim.log 2>/dev/null && echo "Simulation passed" \
    || { echo "Simulation did not pass"; exit 1; }
